//--- verilog/rob_cfg_pkg.sv
// reorder buffer configuration
// sizes of the buffer and of the fields it carries, with their vector types
`default_nettype none

package rob_cfg_pkg;

	//----------------------------------------------------------------------
	// buffer geometry
	//----------------------------------------------------------------------
	localparam int ROB_DEPTH  = 32;
	localparam int ROB_IDX_W  = 5;
	localparam int ROB_PTR_W  = ROB_IDX_W + 1;	// extra wrap bit

	//----------------------------------------------------------------------
	// field widths of the surrounding core
	//----------------------------------------------------------------------
	localparam int PRF_IDX_W  = 6;	// physical register tag
	localparam int ARCH_REG_W = 5;
	localparam int FL_PTR_W   = 5;	// free list head pointer
	localparam int BR_MASK_W  = 4;
	localparam int XLEN       = 64;

	typedef logic [ROB_IDX_W-1:0]  rob_idx_t;
	typedef logic [ROB_PTR_W-1:0]  rob_ptr_t;
	typedef logic [PRF_IDX_W-1:0]  prf_tag_t;
	typedef logic [ARCH_REG_W-1:0] arch_reg_t;
	typedef logic [FL_PTR_W-1:0]   fl_ptr_t;
	typedef logic [BR_MASK_W-1:0]  br_mask_t;
	typedef logic [XLEN-1:0]       addr_t;

endpackage

`default_nettype wire

//--- verilog/rob_types_pkg.sv
// reorder buffer bundles
// structs passed between the buffer blocks and the rest of the core
`default_nettype none

package rob_types_pkg;
	import rob_cfg_pkg::*;

	//----------------------------------------------------------------------
	// dispatch side
	//----------------------------------------------------------------------
	typedef struct packed {
		prf_tag_t  dest_tag;		// new mapping from the free list
		prf_tag_t  old_tag;			// previous mapping, freed on retire
		arch_reg_t arch_reg;
		fl_ptr_t   fl_head;			// free list head at dispatch
		logic      br_flag;
		logic      br_pred_taken;
		addr_t     br_pred_target;
		br_mask_t  br_mask;
		logic      halt;
		logic      illegal;
	} rob_dispatch_t;

	// one stored slot
	typedef struct packed {
		rob_dispatch_t info;
		logic          done;
	} rob_entry_t;

	//----------------------------------------------------------------------
	// retire side
	//----------------------------------------------------------------------
	typedef struct packed {
		logic      valid;
		prf_tag_t  dest_tag;		// goes to the arch map
		prf_tag_t  old_tag;			// goes back to the free list
		arch_reg_t arch_reg;
		logic      halt;
		logic      illegal;
	} rob_retire_t;

	//----------------------------------------------------------------------
	// branch resolution and recovery
	//----------------------------------------------------------------------
	typedef struct packed {
		logic     valid;
		rob_idx_t idx;
		logic     taken;
		addr_t    target;
	} rob_br_resolve_t;

	typedef struct packed {
		logic     valid;
		rob_idx_t idx;				// mispredicted branch, tail restarts after it
		br_mask_t br_mask;
		fl_ptr_t  fl_head;
	} rob_recover_t;

endpackage

`default_nettype wire

//--- verilog/rob_ptr_ctrl.sv
// reorder buffer pointer control
// head and tail with wrap bit, full and stall, retire advance and branch rollback
`timescale 1ns/1ps
`default_nettype none

module rob_ptr_ctrl
	import rob_cfg_pkg::*;
	import rob_types_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         dispatch_valid_i,
	input  logic         head_done_i,
	input  rob_recover_t recover_i,
	output logic         alloc_o,
	output logic         stall_o,
	output logic         retire_valid_o,
	output rob_idx_t     head_idx_o,
	output rob_idx_t     tail_idx_o
);

	rob_ptr_t head_r;
	rob_ptr_t tail_r;
	rob_ptr_t br_ptr;		// branch position with its wrap bit restored
	logic     empty;
	logic     full;

	assign empty = (head_r == tail_r);
	// same slot, different lap
	assign full  = (head_r[ROB_IDX_W-1:0] == tail_r[ROB_IDX_W-1:0]) &&
	               (head_r[ROB_IDX_W] != tail_r[ROB_IDX_W]);

	assign retire_valid_o = head_done_i & ~empty;
	assign stall_o        = full & ~retire_valid_o;	// a retiring head frees its slot now
	assign alloc_o        = dispatch_valid_i & ~stall_o & ~recover_i.valid;

	assign head_idx_o = head_r[ROB_IDX_W-1:0];
	assign tail_idx_o = tail_r[ROB_IDX_W-1:0];

	// the branch lies between head and tail, so its lap follows from the head
	assign br_ptr = {(recover_i.idx >= head_idx_o) ? head_r[ROB_IDX_W] : ~head_r[ROB_IDX_W],
	                 recover_i.idx};

	//----------------------------------------------------------------------
	// pointer update
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
		end else begin
			if (retire_valid_o)
				head_r <= head_r + 1'b1;

			if (recover_i.valid)
				tail_r <= br_ptr + 1'b1;	// rollback wins over dispatch
			else if (alloc_o)
				tail_r <= tail_r + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/rob_entry_store.sv
// reorder buffer entry storage
// tail write, completion marking, head retire and the read ports
`timescale 1ns/1ps
`default_nettype none

module rob_entry_store
	import rob_cfg_pkg::*;
	import rob_types_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  logic          alloc_i,
	input  rob_idx_t      tail_idx_i,
	input  rob_dispatch_t dispatch_i,
	input  rob_idx_t      head_idx_i,
	input  logic          complete_valid_i,
	input  rob_idx_t      complete_idx_i,
	input  rob_idx_t      br_idx_i,
	output logic          head_done_o,
	output rob_retire_t   retire_o,
	output rob_entry_t    br_entry_o
);

	logic [ROB_DEPTH-1:0] done_r;
	rob_dispatch_t        info_r [ROB_DEPTH];
	rob_dispatch_t        head_info;
	logic                 tail_clr;

	// the tail slot is free unless head and tail meet on a full buffer.
	// clearing it also drops done bits left behind by squashed entries
	assign tail_clr = alloc_i | (head_idx_i != tail_idx_i);

	assign head_info   = info_r[head_idx_i];
	assign head_done_o = done_r[head_idx_i];

	//----------------------------------------------------------------------
	// done bits
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			done_r <= '0;
		end else begin
			if (head_done_o)
				done_r[head_idx_i] <= 1'b0;		// head retires, slot freed
			if (tail_clr)
				done_r[tail_idx_i] <= 1'b0;
			// completion last so it beats the head clear
			if (complete_valid_i)
				done_r[complete_idx_i] <= 1'b1;
		end
	end

	// payload only changes on allocation
	always_ff @(posedge clk) begin
		if (alloc_i)
			info_r[tail_idx_i] <= dispatch_i;
	end

	//----------------------------------------------------------------------
	// read ports
	//----------------------------------------------------------------------
	always_comb begin
		retire_o = '0;		// all fields zero while nothing retires
		if (head_done_o) begin
			retire_o.valid    = 1'b1;
			retire_o.dest_tag = head_info.dest_tag;
			retire_o.old_tag  = head_info.old_tag;
			retire_o.arch_reg = head_info.arch_reg;
			retire_o.halt     = head_info.halt;
			retire_o.illegal  = head_info.illegal;
		end
	end

	always_comb begin
		br_entry_o.info = info_r[br_idx_i];	// entry named by the branch unit
		br_entry_o.done = done_r[br_idx_i];
	end

endmodule

`default_nettype wire

//--- verilog/rob_branch_check.sv
// reorder buffer branch check
// compares a resolved branch with its prediction and builds the recovery bundle
`timescale 1ns/1ps
`default_nettype none

module rob_branch_check
	import rob_cfg_pkg::*;
	import rob_types_pkg::*;
(
	input  rob_br_resolve_t br_resolve_i,
	input  rob_entry_t      br_entry_i,
	output rob_recover_t    recover_o,
	output logic            br_correct_o
);

	addr_t tgt_diff;
	logic  hit;
	logic  dir_miss;
	logic  tgt_miss;

	// only a live branch entry can be checked
	assign hit      = br_resolve_i.valid & br_entry_i.info.br_flag;
	assign dir_miss = br_resolve_i.taken != br_entry_i.info.br_pred_taken;
	assign tgt_diff = br_resolve_i.target ^ br_entry_i.info.br_pred_target;
	assign tgt_miss = |tgt_diff;

	always_comb begin
		recover_o    = '0;
		br_correct_o = 1'b0;
		if (hit) begin
			if (dir_miss | tgt_miss) begin
				// squash everything younger than the branch
				recover_o.valid   = 1'b1;
				recover_o.idx     = br_resolve_i.idx;
				recover_o.br_mask = br_entry_i.info.br_mask;
				recover_o.fl_head = br_entry_i.info.fl_head;
			end else begin
				br_correct_o = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/rob.sv
// reorder buffer top level
// pointer control, entry storage and branch check joined together
`timescale 1ns/1ps
`default_nettype none

module rob
	import rob_cfg_pkg::*;
	import rob_types_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	input  logic            dispatch_valid_i,
	input  rob_dispatch_t   dispatch_i,
	input  logic            complete_valid_i,
	input  rob_idx_t        complete_idx_i,
	input  rob_br_resolve_t br_resolve_i,
	output logic            stall_o,
	output rob_idx_t        tail_idx_o,
	output rob_retire_t     retire_o,
	output rob_recover_t    recover_o,
	output logic            br_correct_o
);

	logic       alloc;
	logic       head_done;
	rob_idx_t   head_idx;
	rob_entry_t br_entry;

	//----------------------------------------------------------------------
	// pointers
	//----------------------------------------------------------------------
	rob_ptr_ctrl ptr_ctrl_i (
		.clk              (clk),
		.rst              (rst),
		.dispatch_valid_i (dispatch_valid_i),
		.head_done_i      (head_done),
		.recover_i        (recover_o),
		.alloc_o          (alloc),
		.stall_o          (stall_o),
		.retire_valid_o   (),			// retire_o.valid carries this outward
		.head_idx_o       (head_idx),
		.tail_idx_o       (tail_idx_o)
	);

	//----------------------------------------------------------------------
	// storage
	//----------------------------------------------------------------------
	rob_entry_store entry_store_i (
		.clk              (clk),
		.rst              (rst),
		.alloc_i          (alloc),
		.tail_idx_i       (tail_idx_o),
		.dispatch_i       (dispatch_i),
		.head_idx_i       (head_idx),
		.complete_valid_i (complete_valid_i),
		.complete_idx_i   (complete_idx_i),
		.br_idx_i         (br_resolve_i.idx),
		.head_done_o      (head_done),
		.retire_o         (retire_o),
		.br_entry_o       (br_entry)
	);

	rob_branch_check branch_check_i (
		.br_resolve_i (br_resolve_i),
		.br_entry_i   (br_entry),
		.recover_o    (recover_o),	// also rolls back the tail
		.br_correct_o (br_correct_o)
	);

endmodule

`default_nettype wire

//--- dv/rob_tb.sv
// reorder buffer testbench
// table-driven stimulus checked against a queue model of the buffer
`timescale 1ns/1ps
`default_nettype none

module rob_tb
	import rob_cfg_pkg::*;
	import rob_types_pkg::*;
();

	typedef enum logic [1:0] {OP_IDLE, OP_DISPATCH, OP_COMPLETE, OP_RESOLVE} op_e;

	typedef struct packed {
		logic [2:0]    test;
		op_e           op;
		rob_idx_t      idx;		// completion or branch index
		logic          taken;
		addr_t         target;
		rob_dispatch_t disp;
	} row_t;

	logic            clk;
	logic            rst;
	logic            dispatch_valid;
	rob_dispatch_t   dispatch;
	logic            complete_valid;
	rob_idx_t        complete_idx;
	rob_br_resolve_t br_resolve;
	logic            stall;
	rob_idx_t        tail_idx;
	rob_retire_t     retire;
	rob_recover_t    recover;
	logic            br_correct;

	row_t          table_q [$];
	rob_dispatch_t model_q [$];		// in flight, oldest first
	logic          model_done [$];
	int            model_head;
	rob_idx_t      bld_tail;		// tail as seen while the table is built
	int            table_len;
	int            err_cnt;
	int            check_cnt;

	string test_name [1:6] = '{"in-order retirement", "younger entries completing first",
		"full buffer stall", "correctly predicted branch", "mispredict recovery",
		"halt and illegal flags"};

	rob rob_i (
		.clk              (clk),
		.rst              (rst),
		.dispatch_valid_i (dispatch_valid),
		.dispatch_i       (dispatch),
		.complete_valid_i (complete_valid),
		.complete_idx_i   (complete_idx),
		.br_resolve_i     (br_resolve),
		.stall_o          (stall),
		.tail_idx_o       (tail_idx),
		.retire_o         (retire),
		.recover_o        (recover),
		.br_correct_o     (br_correct)
	);

	always #20 clk = ~clk;

	//----------------------------------------------------------------------
	// table building
	//----------------------------------------------------------------------
	task automatic add_row(input int test, input op_e op, input rob_idx_t idx,
		input logic taken, input addr_t target);
		row_t row;
		row        = '0;
		row.test   = 3'(test);
		row.op     = op;
		row.idx    = idx;
		row.taken  = taken;
		row.target = target;
		table_q.push_back(row);
	endtask

	task automatic add_dispatch(input int test, input logic br, input logic pred,
		input addr_t tgt, input logic halt, input logic ill);
		row_t row;
		row                     = '0;
		row.test                = 3'(test);
		row.op                  = OP_DISPATCH;
		row.disp.dest_tag       = prf_tag_t'($urandom);
		row.disp.old_tag        = prf_tag_t'($urandom);
		row.disp.arch_reg       = arch_reg_t'($urandom);
		row.disp.fl_head        = fl_ptr_t'($urandom);
		row.disp.br_mask        = br_mask_t'($urandom);
		row.disp.br_flag        = br;
		row.disp.br_pred_taken  = pred;
		row.disp.br_pred_target = tgt;
		row.disp.halt           = halt;
		row.disp.illegal        = ill;
		table_q.push_back(row);
		bld_tail = bld_tail + 5'd1;
	endtask

	task automatic add_plain(input int test, input int n);
		repeat (n) add_dispatch(test, 1'b0, 1'b0, '0, 1'b0, 1'b0);
	endtask

	task automatic add_idle(input int test, input int n);
		repeat (n) add_row(test, OP_IDLE, '0, 1'b0, '0);
	endtask

	//----------------------------------------------------------------------
	// drive, model and compare
	//----------------------------------------------------------------------
	task automatic drive_row(input row_t row);
		dispatch_valid    = (row.op == OP_DISPATCH);
		dispatch          = row.disp;
		complete_valid    = (row.op == OP_COMPLETE);
		complete_idx      = row.idx;
		br_resolve.valid  = (row.op == OP_RESOLVE);
		br_resolve.idx    = row.idx;
		br_resolve.taken  = row.taken;
		br_resolve.target = row.target;
	endtask

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
		check_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("MISMATCH %s: expected %0h, got %0h", name, exp, act);
		end
	endtask

	task automatic step_model(input row_t row);
		rob_retire_t   exp_ret;
		rob_recover_t  exp_rec;
		rob_dispatch_t br;
		logic          head_done;
		logic          exp_stall;
		logic          exp_correct;
		int            pos;
		head_done   = (model_q.size() > 0) && model_done[0];
		exp_stall   = (model_q.size() == ROB_DEPTH) && !head_done;
		exp_ret     = '0;
		exp_rec     = '0;
		exp_correct = 1'b0;
		pos         = (int'(row.idx) + ROB_DEPTH - model_head) % ROB_DEPTH;	// age from head
		if (head_done) begin
			exp_ret.valid    = 1'b1;
			exp_ret.dest_tag = model_q[0].dest_tag;
			exp_ret.old_tag  = model_q[0].old_tag;
			exp_ret.arch_reg = model_q[0].arch_reg;
			exp_ret.halt     = model_q[0].halt;
			exp_ret.illegal  = model_q[0].illegal;
		end
		if (row.op == OP_RESOLVE) begin
			if (pos >= model_q.size()) begin
				err_cnt++;
				$display("resolve names slot %0d, which holds no instruction", row.idx);
			end else begin
				br = model_q[pos];
				if (br.br_flag && (row.taken != br.br_pred_taken ||
				                   row.target != br.br_pred_target)) begin
					exp_rec.valid   = 1'b1;
					exp_rec.idx     = row.idx;
					exp_rec.br_mask = br.br_mask;
					exp_rec.fl_head = br.fl_head;
				end else if (br.br_flag) begin
					exp_correct = 1'b1;
				end
			end
		end
		check_val("tail_idx_o", 64'((model_head + model_q.size()) % ROB_DEPTH), 64'(tail_idx));
		check_val("stall_o", 64'(exp_stall), 64'(stall));
		check_val("retire_o", 64'(exp_ret), 64'(retire));
		check_val("recover_o", 64'(exp_rec), 64'(recover));
		check_val("br_correct_o", 64'(exp_correct), 64'(br_correct));

		// what the coming edge does to the buffer
		if (exp_rec.valid) begin
			while (model_q.size() > pos + 1) begin
				void'(model_q.pop_back());
				void'(model_done.pop_back());
			end
		end
		if (row.op == OP_COMPLETE && pos < model_q.size())
			model_done[pos] = 1'b1;
		if (head_done) begin
			void'(model_q.pop_front());
			void'(model_done.pop_front());
			model_head = (model_head + 1) % ROB_DEPTH;
		end
		if (row.op == OP_DISPATCH && !exp_stall && !exp_rec.valid) begin
			model_q.push_back(row.disp);
			model_done.push_back(1'b0);
		end
	endtask

	task automatic report_test(input logic [2:0] t, input int errs);
		if (errs == 0)
			$display("test %0d %s: ok", t, test_name[t]);
		else
			$display("test %0d %s: %0d errors", t, test_name[t], errs);
	endtask

	initial begin : watchdog
		wait (table_len != 0);
		#(table_len * 40 * 4);
		$display("timeout: the table did not finish within %0d ns", table_len * 160);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		rob_idx_t   b;
		rob_idx_t   c;
		addr_t      tgt;
		logic [2:0] cur_test;
		int         test_errs;
		clk            = 1'b0;
		rst            = 1'b1;
		dispatch_valid = 1'b0;
		dispatch       = '0;
		complete_valid = 1'b0;
		complete_idx   = '0;
		br_resolve     = '0;
		err_cnt        = 0;
		check_cnt      = 0;
		model_head     = 0;
		bld_tail       = '0;
		table_len      = 0;
		void'($urandom(32'h7c02_e899));

		b = bld_tail;
		add_plain(1, 4);
		for (int k = 0; k < 4; k++)
			add_row(1, OP_COMPLETE, b + rob_idx_t'(k), 1'b0, '0);
		add_idle(1, 4);

		b = bld_tail;
		add_plain(2, 4);
		for (int k = 3; k > 0; k--)
			add_row(2, OP_COMPLETE, b + rob_idx_t'(k), 1'b0, '0);
		add_idle(2, 2);
		add_row(2, OP_COMPLETE, b, 1'b0, '0);		// head last, then drain
		add_idle(2, 5);

		b = bld_tail;
		add_plain(3, ROB_DEPTH);
		add_idle(3, 2);
		add_row(3, OP_COMPLETE, b, 1'b0, '0);
		add_plain(3, 1);		// lands in the cycle the head retires
		for (int k = 1; k <= ROB_DEPTH; k++)
			add_row(3, OP_COMPLETE, b + rob_idx_t'(k), 1'b0, '0);
		add_idle(3, 3);

		b   = bld_tail;
		tgt = {$urandom, $urandom};
		add_dispatch(4, 1'b1, 1'b1, tgt, 1'b0, 1'b0);
		add_plain(4, 1);
		add_row(4, OP_RESOLVE, b, 1'b1, tgt);
		add_row(4, OP_COMPLETE, b, 1'b0, '0);
		add_row(4, OP_COMPLETE, b + 5'd1, 1'b0, '0);
		add_idle(4, 3);

		// direction miss over a finished younger entry, then a target miss
		b   = bld_tail;
		tgt = {$urandom, $urandom};
		add_dispatch(5, 1'b1, 1'b0, tgt, 1'b0, 1'b0);
		add_plain(5, 3);
		add_row(5, OP_COMPLETE, b + 5'd2, 1'b0, '0);
		add_row(5, OP_RESOLVE, b, 1'b1, tgt);
		bld_tail = b + 5'd1;
		add_idle(5, 1);
		add_plain(5, 2);
		c   = bld_tail;
		tgt = {$urandom, $urandom};
		add_dispatch(5, 1'b1, 1'b1, tgt, 1'b0, 1'b0);
		add_plain(5, 1);
		add_row(5, OP_RESOLVE, c, 1'b1, tgt ^ 64'h10);
		bld_tail = c + 5'd1;
		for (int k = 0; k < 4; k++)
			add_row(5, OP_COMPLETE, b + rob_idx_t'(k), 1'b0, '0);
		add_idle(5, 3);

		b = bld_tail;
		add_dispatch(6, 1'b0, 1'b0, '0, 1'b1, 1'b0);
		add_dispatch(6, 1'b0, 1'b0, '0, 1'b0, 1'b1);
		add_dispatch(6, 1'b0, 1'b0, '0, 1'b1, 1'b1);
		add_plain(6, 1);
		for (int k = 0; k < 4; k++)
			add_row(6, OP_COMPLETE, b + rob_idx_t'(k), 1'b0, '0);
		add_idle(6, 3);
		table_len = table_q.size();

		repeat (8) @(posedge clk);
		#2;
		rst       = 1'b0;
		cur_test  = 3'd1;
		test_errs = 0;
		foreach (table_q[r]) begin
			if (table_q[r].test != cur_test) begin
				report_test(cur_test, err_cnt - test_errs);
				cur_test  = table_q[r].test;
				test_errs = err_cnt;
			end
			drive_row(table_q[r]);
			@(negedge clk);		// outputs settled, edge not yet taken
			step_model(table_q[r]);
			@(posedge clk);
			#2;
		end
		report_test(cur_test, err_cnt - test_errs);
		$display("checks run %0d, failed %0d", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- rob.f
verilog/rob_cfg_pkg.sv
verilog/rob_types_pkg.sv
verilog/rob_ptr_ctrl.sv
verilog/rob_entry_store.sv
verilog/rob_branch_check.sv
verilog/rob.sv
dv/rob_tb.sv

//--- Makefile
# reorder buffer build with Verilator

RTL := verilog/rob_cfg_pkg.sv verilog/rob_types_pkg.sv verilog/rob_ptr_ctrl.sv \
       verilog/rob_entry_store.sv verilog/rob_branch_check.sv verilog/rob.sv

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --top-module rob $(RTL)

sim:
	verilator --binary --timing -j 0 --top-module rob_tb -f rob.f -Mdir obj_dir
	./obj_dir/Vrob_tb | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
